// File: run_sim.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_id_stage \
	-Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_id_stage > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// File: source/id_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module id_decoder (
	input  id_pkg::word_t     inst_i,
	output id_pkg::alu_op_t   alu_op_o,
	output id_pkg::alu_sel_t  alu_sel_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output logic              reg1_read_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output id_pkg::word_t     imm_o,
	output logic              use_pc_o,
	output logic              inst_valid_o
);

	logic [6:0]    opcode;
	logic [2:0]    funct3;
	logic [6:0]    funct7;
	id_pkg::word_t imm_itype;
	id_pkg::word_t imm_stype;
	id_pkg::word_t imm_btype;
	id_pkg::word_t imm_jtype;
	id_pkg::word_t imm_utype;
	id_pkg::word_t imm_shamt;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_itype = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_stype = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_btype = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_jtype = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_utype = {inst_i[31:12], 12'b0};
	assign imm_shamt = {27'b0, inst_i[24:20]};

	// alu op for the immediate and register groups
	function automatic id_pkg::alu_op_t alu_op_of(input logic [2:0] f3, input logic [6:0] f7,
			input logic is_r);
		id_pkg::alu_op_t op;
		logic            f7_ok;
		case (f3)
			id_pkg::F3_ADD_SUB: op = (is_r && f7 == id_pkg::F7_ALT) ? id_pkg::OP_SUB : id_pkg::OP_ADD;
			id_pkg::F3_SLL:     op = id_pkg::OP_SLL;
			id_pkg::F3_SLT:     op = id_pkg::OP_SLT;
			id_pkg::F3_SLTU:    op = id_pkg::OP_SLTU;
			id_pkg::F3_XOR:     op = id_pkg::OP_XOR;
			id_pkg::F3_SRL_SRA: op = (f7 == id_pkg::F7_ALT) ? id_pkg::OP_SRA : id_pkg::OP_SRL;
			id_pkg::F3_OR:      op = id_pkg::OP_OR;
			default:            op = id_pkg::OP_AND;
		endcase
		// alt funct7 only exists for sub and sra
		f7_ok = (f7 == id_pkg::F7_BASE) || (f7 == id_pkg::F7_ALT &&
			(f3 == id_pkg::F3_SRL_SRA || (is_r && f3 == id_pkg::F3_ADD_SUB)));
		if ((is_r || f3 == id_pkg::F3_SLL || f3 == id_pkg::F3_SRL_SRA) && !f7_ok) begin
			op = id_pkg::OP_NOP;
		end
		return op;
	endfunction

	function automatic id_pkg::alu_sel_t alu_sel_of(input id_pkg::alu_op_t op);
		case (op)
			id_pkg::OP_NOP:                                 return id_pkg::SEL_NOP;
			id_pkg::OP_AND, id_pkg::OP_OR, id_pkg::OP_XOR:  return id_pkg::SEL_LOGIC;
			id_pkg::OP_SLL, id_pkg::OP_SRL, id_pkg::OP_SRA: return id_pkg::SEL_SHIFT;
			default:                                        return id_pkg::SEL_ARITHMETIC;
		endcase
	endfunction

	always_comb begin
		alu_op_o    = id_pkg::OP_NOP;
		alu_sel_o   = id_pkg::SEL_NOP;
		wd_o        = inst_i[11:7];
		wreg_o      = 1'b0;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		reg1_addr_o = inst_i[19:15];
		reg2_addr_o = inst_i[24:20];
		imm_o       = '0;
		use_pc_o    = 1'b0;
		case (opcode)
			id_pkg::OPC_I: begin
				reg1_read_o = 1'b1;
				wreg_o      = 1'b1;
				alu_op_o    = alu_op_of(funct3, funct7, 1'b0);
				alu_sel_o   = alu_sel_of(alu_op_o);
				if (alu_sel_o == id_pkg::SEL_SHIFT) begin
					imm_o = imm_shamt;
				end else begin
					imm_o = imm_itype;
				end
			end
			id_pkg::OPC_R: begin
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				wreg_o      = 1'b1;
				alu_op_o    = alu_op_of(funct3, funct7, 1'b1);
				alu_sel_o   = alu_sel_of(alu_op_o);
			end
			id_pkg::OPC_B: begin
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				alu_sel_o   = id_pkg::SEL_JUMP_BRANCH;
				imm_o       = imm_btype;
				case (funct3)
					id_pkg::F3_BEQ:  alu_op_o = id_pkg::OP_BEQ;
					id_pkg::F3_BNE:  alu_op_o = id_pkg::OP_BNE;
					id_pkg::F3_BLT:  alu_op_o = id_pkg::OP_BLT;
					id_pkg::F3_BGE:  alu_op_o = id_pkg::OP_BGE;
					id_pkg::F3_BLTU: alu_op_o = id_pkg::OP_BLTU;
					id_pkg::F3_BGEU: alu_op_o = id_pkg::OP_BGEU;
					default:         alu_op_o = id_pkg::OP_NOP;
				endcase
			end
			id_pkg::OPC_L: begin
				reg1_read_o = 1'b1;
				wreg_o      = 1'b1;
				alu_sel_o   = id_pkg::SEL_LOAD_STORE;
				imm_o       = imm_itype;
				case (funct3)
					id_pkg::F3_LB:  alu_op_o = id_pkg::OP_LB;
					id_pkg::F3_LH:  alu_op_o = id_pkg::OP_LH;
					id_pkg::F3_LW:  alu_op_o = id_pkg::OP_LW;
					id_pkg::F3_LBU: alu_op_o = id_pkg::OP_LBU;
					id_pkg::F3_LHU: alu_op_o = id_pkg::OP_LHU;
					default:        alu_op_o = id_pkg::OP_NOP;
				endcase
			end
			id_pkg::OPC_S: begin
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1; // store data
				alu_sel_o   = id_pkg::SEL_LOAD_STORE;
				imm_o       = imm_stype;
				case (funct3)
					id_pkg::F3_SB: alu_op_o = id_pkg::OP_SB;
					id_pkg::F3_SH: alu_op_o = id_pkg::OP_SH;
					id_pkg::F3_SW: alu_op_o = id_pkg::OP_SW;
					default:       alu_op_o = id_pkg::OP_NOP;
				endcase
			end
			id_pkg::OPC_LUI: begin
				// x0 | upper immediate
				reg1_read_o = 1'b1;
				reg1_addr_o = '0;
				wreg_o      = 1'b1;
				alu_op_o    = id_pkg::OP_OR;
				alu_sel_o   = id_pkg::SEL_LOGIC;
				imm_o       = imm_utype;
			end
			id_pkg::OPC_AUIPC: begin
				use_pc_o  = 1'b1;
				wreg_o    = 1'b1;
				alu_op_o  = id_pkg::OP_ADD;
				alu_sel_o = id_pkg::SEL_ARITHMETIC;
				imm_o     = imm_utype;
			end
			id_pkg::OPC_JAL: begin
				wreg_o    = 1'b1;
				wd_o      = id_pkg::LINK_REG;
				alu_op_o  = id_pkg::OP_JAL;
				alu_sel_o = id_pkg::SEL_JUMP_BRANCH;
				imm_o     = imm_jtype;
			end
			id_pkg::OPC_JALR: begin
				reg1_read_o = 1'b1;
				wreg_o      = 1'b1;
				alu_sel_o   = id_pkg::SEL_JUMP_BRANCH;
				imm_o       = imm_itype;
				if (funct3 == id_pkg::F3_JALR) begin
					alu_op_o = id_pkg::OP_JALR;
				end
			end
			default: alu_op_o = id_pkg::OP_NOP;
		endcase
		inst_valid_o = (alu_op_o != id_pkg::OP_NOP);
		if (!inst_valid_o) begin // unmatched encoding goes out as a bubble
			alu_sel_o   = id_pkg::SEL_NOP;
			wreg_o      = 1'b0;
			reg1_read_o = 1'b0;
			reg2_read_o = 1'b0;
			use_pc_o    = 1'b0;
		end
	end

	always_comb begin
		assert (inst_valid_o || !wreg_o)
			else $error("register write requested for an invalid instruction");
	end

endmodule

`default_nettype wire

// File: source/id_issue.sv
`default_nettype none
`timescale 1ns/1ps

module id_issue (
	input  logic              clk,
	input  logic              rst_n_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::alu_op_t   alu_op_i,
	input  id_pkg::alu_sel_t  alu_sel_i,
	input  id_pkg::reg_addr_t wd_i,
	input  logic              wreg_i,
	input  id_pkg::word_t     imm_i,
	input  logic              inst_valid_i,
	input  id_pkg::word_t     op1_i,
	input  id_pkg::word_t     op2_i,
	input  logic              stall_i,
	output id_pkg::alu_op_t   ex_aluop_o,
	output id_pkg::alu_sel_t  ex_alusel_o,
	output id_pkg::word_t     ex_reg1_o,
	output id_pkg::word_t     ex_reg2_o,
	output id_pkg::reg_addr_t ex_wd_o,
	output logic              ex_wreg_o,
	output id_pkg::word_t     ex_link_addr_o,
	output logic              ex_inst_valid_o,
	output logic              branch_flag_o,
	output id_pkg::word_t     branch_target_o
);

	logic          taken;
	logic          is_jump;
	id_pkg::word_t jalr_sum;
	id_pkg::word_t target;
	id_pkg::word_t link_addr;

	always_comb begin
		case (alu_op_i)
			id_pkg::OP_BEQ:  taken = (op1_i == op2_i);
			id_pkg::OP_BNE:  taken = (op1_i != op2_i);
			id_pkg::OP_BLT:  taken = ($signed(op1_i) < $signed(op2_i));
			id_pkg::OP_BGE:  taken = ($signed(op1_i) >= $signed(op2_i));
			id_pkg::OP_BLTU: taken = (op1_i < op2_i);
			id_pkg::OP_BGEU: taken = (op1_i >= op2_i);
			id_pkg::OP_JAL, id_pkg::OP_JALR: taken = 1'b1;
			default:         taken = 1'b0;
		endcase
	end

	assign is_jump  = (alu_op_i == id_pkg::OP_JAL) || (alu_op_i == id_pkg::OP_JALR);
	assign jalr_sum = op1_i + imm_i; // op1 is the forwarded rs1
	assign target   = (alu_op_i == id_pkg::OP_JALR) ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;
	assign link_addr = is_jump ? pc_i + 32'd4 : '0;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_aluop_o      <= id_pkg::OP_NOP;
			ex_alusel_o     <= id_pkg::SEL_NOP;
			ex_reg1_o       <= '0;
			ex_reg2_o       <= '0;
			ex_wd_o         <= '0;
			ex_wreg_o       <= 1'b0;
			ex_link_addr_o  <= '0;
			ex_inst_valid_o <= 1'b0;
			branch_flag_o   <= 1'b0;
			branch_target_o <= '0;
		end else if (stall_i) begin
			// bubble while the load result is pending
			ex_aluop_o      <= id_pkg::OP_NOP;
			ex_alusel_o     <= id_pkg::SEL_NOP;
			ex_reg1_o       <= '0;
			ex_reg2_o       <= '0;
			ex_wd_o         <= '0;
			ex_wreg_o       <= 1'b0;
			ex_link_addr_o  <= '0;
			ex_inst_valid_o <= 1'b1;
			branch_flag_o   <= 1'b0;
			branch_target_o <= '0;
		end else begin
			ex_aluop_o      <= alu_op_i;
			ex_alusel_o     <= alu_sel_i;
			ex_reg1_o       <= op1_i;
			ex_reg2_o       <= op2_i;
			ex_wd_o         <= wd_i;
			ex_wreg_o       <= wreg_i;
			ex_link_addr_o  <= link_addr;
			ex_inst_valid_o <= inst_valid_i;
			branch_flag_o   <= taken;
			branch_target_o <= taken ? target : '0; // zero when falling through
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n_i) stall_i |=> (!ex_wreg_o && !branch_flag_o))
		else $error("no bubble issued after a stall");

endmodule

`default_nettype wire

// File: source/id_operand_mux.sv
`default_nettype none
`timescale 1ns/1ps

module id_operand_mux (
	input  logic              clk,
	input  logic              rst_n_i,
	input  id_pkg::word_t     pc_i,
	input  logic              reg1_read_i,
	input  logic              reg2_read_i,
	input  id_pkg::reg_addr_t reg1_addr_i,
	input  id_pkg::reg_addr_t reg2_addr_i,
	input  id_pkg::word_t     imm_i,
	input  logic              use_pc_i,
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	input  logic              ex_wreg_i,
	input  id_pkg::reg_addr_t ex_wd_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  id_pkg::alu_op_t   ex_aluop_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	input  id_pkg::word_t     mem_wdata_i,
	output id_pkg::word_t     op1_o,
	output id_pkg::word_t     op2_o,
	output logic              stall_o
);

	logic ex_is_load;
	logic hazard1;
	logic hazard2;

	// newest producer wins, x0 always reads as register data
	function automatic id_pkg::word_t fwd(input id_pkg::reg_addr_t addr, input id_pkg::word_t rf_data);
		if (addr == '0) begin
			return rf_data;
		end else if (ex_wreg_i && ex_wd_i == addr) begin
			return ex_wdata_i;
		end else if (mem_wreg_i && mem_wd_i == addr) begin
			return mem_wdata_i;
		end
		return rf_data;
	endfunction

	always_comb begin
		if (reg1_read_i) begin
			op1_o = fwd(reg1_addr_i, reg1_data_i);
		end else begin
			op1_o = use_pc_i ? pc_i : imm_i; // auipc takes the pc
		end
		if (reg2_read_i) begin
			op2_o = fwd(reg2_addr_i, reg2_data_i);
		end else begin
			op2_o = imm_i;
		end
	end

	// load result not ready until after mem
	assign ex_is_load = ex_aluop_i inside {id_pkg::OP_LB, id_pkg::OP_LH, id_pkg::OP_LW,
		id_pkg::OP_LBU, id_pkg::OP_LHU};

	assign hazard1 = reg1_read_i && (reg1_addr_i != '0) && (ex_wd_i == reg1_addr_i);
	assign hazard2 = reg2_read_i && (reg2_addr_i != '0) && (ex_wd_i == reg2_addr_i);
	assign stall_o = ex_is_load && (hazard1 || hazard2);

	assert property (@(posedge clk) disable iff (!rst_n_i) stall_o |-> (reg1_read_i || reg2_read_i))
		else $error("stall raised with no register read");

endmodule

`default_nettype wire

// File: source/id_pkg.sv
`default_nettype none

package id_pkg;

	typedef logic [31:0] word_t;     // data or address word
	typedef logic [4:0]  reg_addr_t;
	typedef logic [7:0]  alu_op_t;
	typedef logic [2:0]  alu_sel_t;  // result class seen by execute

	localparam alu_sel_t SEL_NOP         = 3'd0;
	localparam alu_sel_t SEL_LOGIC       = 3'd1;
	localparam alu_sel_t SEL_SHIFT       = 3'd2;
	localparam alu_sel_t SEL_ARITHMETIC  = 3'd3;
	localparam alu_sel_t SEL_JUMP_BRANCH = 3'd4;
	localparam alu_sel_t SEL_LOAD_STORE  = 3'd5;

	// alu ops grouped by result class
	localparam alu_op_t OP_NOP  = 8'h00;
	localparam alu_op_t OP_AND  = 8'h10;
	localparam alu_op_t OP_OR   = 8'h11;
	localparam alu_op_t OP_XOR  = 8'h12;
	localparam alu_op_t OP_SLL  = 8'h20;
	localparam alu_op_t OP_SRL  = 8'h21;
	localparam alu_op_t OP_SRA  = 8'h22;
	localparam alu_op_t OP_ADD  = 8'h30;
	localparam alu_op_t OP_SUB  = 8'h31;
	localparam alu_op_t OP_SLT  = 8'h32;
	localparam alu_op_t OP_SLTU = 8'h33;
	localparam alu_op_t OP_LB   = 8'h40;
	localparam alu_op_t OP_LH   = 8'h41;
	localparam alu_op_t OP_LW   = 8'h42;
	localparam alu_op_t OP_LBU  = 8'h43;
	localparam alu_op_t OP_LHU  = 8'h44;
	localparam alu_op_t OP_SB   = 8'h48;
	localparam alu_op_t OP_SH   = 8'h49;
	localparam alu_op_t OP_SW   = 8'h4a;
	localparam alu_op_t OP_BEQ  = 8'h50;
	localparam alu_op_t OP_BNE  = 8'h51;
	localparam alu_op_t OP_BLT  = 8'h52;
	localparam alu_op_t OP_BGE  = 8'h53;
	localparam alu_op_t OP_BLTU = 8'h54;
	localparam alu_op_t OP_BGEU = 8'h55;
	localparam alu_op_t OP_JAL  = 8'h58;
	localparam alu_op_t OP_JALR = 8'h59;

	localparam logic [6:0] OPC_I     = 7'b0010011;
	localparam logic [6:0] OPC_R     = 7'b0110011;
	localparam logic [6:0] OPC_B     = 7'b1100011;
	localparam logic [6:0] OPC_L     = 7'b0000011;
	localparam logic [6:0] OPC_S     = 7'b0100011;
	localparam logic [6:0] OPC_LUI   = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL   = 7'b1101111;
	localparam logic [6:0] OPC_JALR  = 7'b1100111;

	// funct3 of the alu groups
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_LB   = 3'b000;
	localparam logic [2:0] F3_LH   = 3'b001;
	localparam logic [2:0] F3_LW   = 3'b010;
	localparam logic [2:0] F3_LBU  = 3'b100;
	localparam logic [2:0] F3_LHU  = 3'b101;
	localparam logic [2:0] F3_SB   = 3'b000;
	localparam logic [2:0] F3_SH   = 3'b001;
	localparam logic [2:0] F3_SW   = 3'b010;
	localparam logic [2:0] F3_JALR = 3'b000;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and sra

	localparam reg_addr_t LINK_REG = 5'd1; // ra

endpackage

`default_nettype wire

// File: source/id_stage.sv
`default_nettype none
`timescale 1ns/1ps

module id_stage (
	input  logic              clk,
	input  logic              rst_n_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	input  logic              ex_wreg_i,
	input  id_pkg::reg_addr_t ex_wd_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  id_pkg::alu_op_t   ex_aluop_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	input  id_pkg::word_t     mem_wdata_i,
	output logic              reg1_read_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output logic              stall_o,
	output id_pkg::alu_op_t   ex_aluop_o,
	output id_pkg::alu_sel_t  ex_alusel_o,
	output id_pkg::word_t     ex_reg1_o,
	output id_pkg::word_t     ex_reg2_o,
	output id_pkg::reg_addr_t ex_wd_o,
	output logic              ex_wreg_o,
	output id_pkg::word_t     ex_link_addr_o,
	output logic              ex_inst_valid_o,
	output logic              branch_flag_o,
	output id_pkg::word_t     branch_target_o
);

	id_pkg::alu_op_t   alu_op;
	id_pkg::alu_sel_t  alu_sel;
	id_pkg::reg_addr_t wd;
	logic              wreg;
	id_pkg::word_t     imm;
	logic              use_pc;
	logic              inst_valid;
	id_pkg::word_t     op1;
	id_pkg::word_t     op2;

	id_decoder decoder_i (
		.inst_i       (inst_i),
		.alu_op_o     (alu_op),
		.alu_sel_o    (alu_sel),
		.wd_o         (wd),
		.wreg_o       (wreg),
		.reg1_read_o  (reg1_read_o),
		.reg2_read_o  (reg2_read_o),
		.reg1_addr_o  (reg1_addr_o),
		.reg2_addr_o  (reg2_addr_o),
		.imm_o        (imm),
		.use_pc_o     (use_pc),
		.inst_valid_o (inst_valid)
	);

	id_operand_mux operand_mux_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.pc_i        (pc_i),
		.reg1_read_i (reg1_read_o),
		.reg2_read_i (reg2_read_o),
		.reg1_addr_i (reg1_addr_o),
		.reg2_addr_i (reg2_addr_o),
		.imm_i       (imm),
		.use_pc_i    (use_pc),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.ex_aluop_i  (ex_aluop_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.op1_o       (op1),
		.op2_o       (op2),
		.stall_o     (stall_o)
	);

	id_issue issue_i (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.pc_i            (pc_i),
		.alu_op_i        (alu_op),
		.alu_sel_i       (alu_sel),
		.wd_i            (wd),
		.wreg_i          (wreg),
		.imm_i           (imm),
		.inst_valid_i    (inst_valid),
		.op1_i           (op1),
		.op2_i           (op2),
		.stall_i         (stall_o),
		.ex_aluop_o      (ex_aluop_o),
		.ex_alusel_o     (ex_alusel_o),
		.ex_reg1_o       (ex_reg1_o),
		.ex_reg2_o       (ex_reg2_o),
		.ex_wd_o         (ex_wd_o),
		.ex_wreg_o       (ex_wreg_o),
		.ex_link_addr_o  (ex_link_addr_o),
		.ex_inst_valid_o (ex_inst_valid_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o)
	);

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
source/id_pkg.sv
source/id_decoder.sv
source/id_operand_mux.sv
source/id_issue.sv
source/id_stage.sv
tb/tb_id_stage.sv

// File: tb/id_vectors.svh
`ifndef ID_VECTORS_SVH
`define ID_VECTORS_SVH

// inputs are pc, inst, reg data, filler, ex wreg/wd/wdata/aluop, mem wreg/wd/wdata
// expected are stall, read enables, read addrs, op, sel, reg1, reg2, wd, wreg, link, valid, flag, target
typedef struct packed {
	id_pkg::word_t     pc;
	id_pkg::word_t     inst;
	id_pkg::word_t     r1;
	id_pkg::word_t     r2;
	logic              fill;       // random register data for unread operands
	logic              ex_wreg;
	id_pkg::reg_addr_t ex_wd;
	id_pkg::word_t     ex_wdata;
	id_pkg::alu_op_t   ex_aluop;
	logic              mem_wreg;
	id_pkg::reg_addr_t mem_wd;
	id_pkg::word_t     mem_wdata;
	logic              stall;
	logic              rd1;
	logic              rd2;
	id_pkg::reg_addr_t ra1;
	id_pkg::reg_addr_t ra2;
	id_pkg::alu_op_t   op;
	id_pkg::alu_sel_t  sel;
	id_pkg::word_t     reg1;
	id_pkg::word_t     reg2;
	id_pkg::reg_addr_t wd;
	logic              wreg;
	id_pkg::word_t     link;
	logic              valid;
	logic              flag;
	id_pkg::word_t     target;
} vec_t;

localparam int NUM_VEC = 29;

vec_t vectors [NUM_VEC] = '{
	// addi x7, x5, -4
	'{32'h100, 32'hffc28393, 32'h11, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b0, 5'd5, 5'd28, id_pkg::OP_ADD, id_pkg::SEL_ARITHMETIC,
		32'h11, 32'hfffffffc, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// andi x7, x5, 0xf0
	'{32'h104, 32'h0f02f393, 32'h11, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b0, 5'd5, 5'd16, id_pkg::OP_AND, id_pkg::SEL_LOGIC,
		32'h11, 32'hf0, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// slli x7, x5, 3
	'{32'h108, 32'h00329393, 32'h11, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b0, 5'd5, 5'd3, id_pkg::OP_SLL, id_pkg::SEL_SHIFT,
		32'h11, 32'h3, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// srai x7, x5, 4
	'{32'h10c, 32'h4042d393, 32'h11, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b0, 5'd5, 5'd4, id_pkg::OP_SRA, id_pkg::SEL_SHIFT,
		32'h11, 32'h4, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// add x7, x5, x6
	'{32'h110, 32'h006283b3, 32'h11, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_ADD, id_pkg::SEL_ARITHMETIC,
		32'h11, 32'h22, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// sub
	'{32'h114, 32'h406283b3, 32'h11, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_SUB, id_pkg::SEL_ARITHMETIC,
		32'h11, 32'h22, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// slt
	'{32'h118, 32'h0062a3b3, 32'h11, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_SLT, id_pkg::SEL_ARITHMETIC,
		32'h11, 32'h22, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// xor
	'{32'h11c, 32'h0062c3b3, 32'h11, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_XOR, id_pkg::SEL_LOGIC,
		32'h11, 32'h22, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// unknown opcode
	'{32'h120, 32'h0000007f, 32'h0, 32'h0, 1'b1,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b0, 1'b0, 5'd0, 5'd0, id_pkg::OP_NOP, id_pkg::SEL_NOP,
		32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0},
	// ex and mem both write x5 and ex wins
	'{32'h124, 32'h006283b3, 32'h11, 32'h22, 1'b0,
		1'b1, 5'd5, 32'haaaa0001, id_pkg::OP_ADD, 1'b1, 5'd5, 32'hbbbb0002,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_ADD, id_pkg::SEL_ARITHMETIC,
		32'haaaa0001, 32'h22, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// only mem writes x5
	'{32'h128, 32'h006283b3, 32'h11, 32'h22, 1'b0,
		1'b1, 5'd9, 32'haaaa0001, id_pkg::OP_ADD, 1'b1, 5'd5, 32'hbbbb0002,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_ADD, id_pkg::SEL_ARITHMETIC,
		32'hbbbb0002, 32'h22, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// add x7, x0, x6 with both stages writing x0
	'{32'h12c, 32'h006003b3, 32'h11, 32'h22, 1'b0,
		1'b1, 5'd0, 32'haaaa0001, id_pkg::OP_ADD, 1'b1, 5'd0, 32'hbbbb0002,
		1'b0, 1'b1, 1'b1, 5'd0, 5'd6, id_pkg::OP_ADD, id_pkg::SEL_ARITHMETIC,
		32'h11, 32'h22, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// lw to x6 in execute while add reads x6
	'{32'h130, 32'h006283b3, 32'h11, 32'h22, 1'b0,
		1'b1, 5'd6, 32'hcccc0003, id_pkg::OP_LW, 1'b0, 5'd0, 32'h0,
		1'b1, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_NOP, id_pkg::SEL_NOP,
		32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0},
	// branches at pc 0x100 with offset 16
	'{32'h100, 32'h00628863, 32'h5, 32'h5, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BEQ, id_pkg::SEL_JUMP_BRANCH,
		32'h5, 32'h5, 5'd16, 1'b0, 32'h0, 1'b1, 1'b1, 32'h110},
	'{32'h100, 32'h00628863, 32'h5, 32'h6, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BEQ, id_pkg::SEL_JUMP_BRANCH,
		32'h5, 32'h6, 5'd16, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0},
	'{32'h100, 32'h00629863, 32'h5, 32'h6, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BNE, id_pkg::SEL_JUMP_BRANCH,
		32'h5, 32'h6, 5'd16, 1'b0, 32'h0, 1'b1, 1'b1, 32'h110},
	'{32'h100, 32'h00629863, 32'h5, 32'h5, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BNE, id_pkg::SEL_JUMP_BRANCH,
		32'h5, 32'h5, 5'd16, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0},
	// -1 < 1 signed
	'{32'h100, 32'h0062c863, 32'hffffffff, 32'h1, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BLT, id_pkg::SEL_JUMP_BRANCH,
		32'hffffffff, 32'h1, 5'd16, 1'b0, 32'h0, 1'b1, 1'b1, 32'h110},
	'{32'h100, 32'h0062c863, 32'h3, 32'h2, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BLT, id_pkg::SEL_JUMP_BRANCH,
		32'h3, 32'h2, 5'd16, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0},
	'{32'h100, 32'h0062d863, 32'h1, 32'hffffffff, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BGE, id_pkg::SEL_JUMP_BRANCH,
		32'h1, 32'hffffffff, 5'd16, 1'b0, 32'h0, 1'b1, 1'b1, 32'h110},
	'{32'h100, 32'h0062d863, 32'hffffffff, 32'h1, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BGE, id_pkg::SEL_JUMP_BRANCH,
		32'hffffffff, 32'h1, 5'd16, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0},
	// unsigned view of the same operands
	'{32'h100, 32'h0062e863, 32'h1, 32'hffffffff, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BLTU, id_pkg::SEL_JUMP_BRANCH,
		32'h1, 32'hffffffff, 5'd16, 1'b0, 32'h0, 1'b1, 1'b1, 32'h110},
	'{32'h100, 32'h0062e863, 32'hffffffff, 32'h1, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BLTU, id_pkg::SEL_JUMP_BRANCH,
		32'hffffffff, 32'h1, 5'd16, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0},
	'{32'h100, 32'h0062f863, 32'hffffffff, 32'h1, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BGEU, id_pkg::SEL_JUMP_BRANCH,
		32'hffffffff, 32'h1, 5'd16, 1'b0, 32'h0, 1'b1, 1'b1, 32'h110},
	'{32'h100, 32'h0062f863, 32'h1, 32'hffffffff, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b1, 5'd5, 5'd6, id_pkg::OP_BGEU, id_pkg::SEL_JUMP_BRANCH,
		32'h1, 32'hffffffff, 5'd16, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0},
	// jal x1, +0x20
	'{32'h200, 32'h020000ef, 32'h0, 32'h0, 1'b1,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b0, 1'b0, 5'd0, 5'd0, id_pkg::OP_JAL, id_pkg::SEL_JUMP_BRANCH,
		32'h20, 32'h20, 5'd1, 1'b1, 32'h204, 1'b1, 1'b1, 32'h220},
	// jalr x1, 4(x5) with x5 forwarded from execute
	'{32'h300, 32'h004280e7, 32'h1000, 32'h22, 1'b0,
		1'b1, 5'd5, 32'h3001, id_pkg::OP_ADD, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b0, 5'd5, 5'd4, id_pkg::OP_JALR, id_pkg::SEL_JUMP_BRANCH,
		32'h3001, 32'h4, 5'd1, 1'b1, 32'h304, 1'b1, 1'b1, 32'h3004},
	// lui x7, 0x12345
	'{32'h400, 32'h123453b7, 32'h0, 32'h22, 1'b0,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b1, 1'b0, 5'd0, 5'd3, id_pkg::OP_OR, id_pkg::SEL_LOGIC,
		32'h0, 32'h12345000, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0},
	// auipc x7, 0x1
	'{32'h500, 32'h00001397, 32'h0, 32'h0, 1'b1,
		1'b0, 5'd0, 32'h0, id_pkg::OP_NOP, 1'b0, 5'd0, 32'h0,
		1'b0, 1'b0, 1'b0, 5'd0, 5'd0, id_pkg::OP_ADD, id_pkg::SEL_ARITHMETIC,
		32'h500, 32'h1000, 5'd7, 1'b1, 32'h0, 1'b1, 1'b0, 32'h0}
};

`endif

// File: tb/tb_id_stage.sv
`default_nettype none
`timescale 1ns/1ps

module tb_id_stage;

	logic              clk;
	logic              rst_n_i;
	id_pkg::word_t     pc_i;
	id_pkg::word_t     inst_i;
	id_pkg::word_t     reg1_data_i;
	id_pkg::word_t     reg2_data_i;
	logic              ex_wreg_i;
	id_pkg::reg_addr_t ex_wd_i;
	id_pkg::word_t     ex_wdata_i;
	id_pkg::alu_op_t   ex_aluop_i;
	logic              mem_wreg_i;
	id_pkg::reg_addr_t mem_wd_i;
	id_pkg::word_t     mem_wdata_i;
	logic              reg1_read_o;
	logic              reg2_read_o;
	id_pkg::reg_addr_t reg1_addr_o;
	id_pkg::reg_addr_t reg2_addr_o;
	logic              stall_o;
	id_pkg::alu_op_t   ex_aluop_o;
	id_pkg::alu_sel_t  ex_alusel_o;
	id_pkg::word_t     ex_reg1_o;
	id_pkg::word_t     ex_reg2_o;
	id_pkg::reg_addr_t ex_wd_o;
	logic              ex_wreg_o;
	id_pkg::word_t     ex_link_addr_o;
	logic              ex_inst_valid_o;
	logic              branch_flag_o;
	id_pkg::word_t     branch_target_o;

	int checks;
	int errors;

	`include "id_vectors.svh"

	id_stage id_stage_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// wait until clk reaches the given level within a few toggles
	task automatic wait_clk(input logic level);
		int   n;
		logic hit;
		hit = 1'b0;
		for (n = 0; n < 4 && !hit; n++) begin
			@(clk);
			hit = (clk == level);
		end
		if (!hit) begin
			$display("timed out waiting for a clock edge");
			$display("CHECKS FAILED");
			$finish;
		end
	endtask

	task automatic check(input string name, input int row, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERR row %0d %s expected %h got %h", row, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_ex(input int row, input vec_t v);
		check("ex_aluop_o", row, 32'(ex_aluop_o), 32'(v.op));
		check("ex_alusel_o", row, 32'(ex_alusel_o), 32'(v.sel));
		check("ex_reg1_o", row, ex_reg1_o, v.reg1);
		check("ex_reg2_o", row, ex_reg2_o, v.reg2);
		check("ex_wd_o", row, 32'(ex_wd_o), 32'(v.wd));
		check("ex_wreg_o", row, 32'(ex_wreg_o), 32'(v.wreg));
		check("ex_link_addr_o", row, ex_link_addr_o, v.link);
		check("ex_inst_valid_o", row, 32'(ex_inst_valid_o), 32'(v.valid));
		check("branch_flag_o", row, 32'(branch_flag_o), 32'(v.flag));
		check("branch_target_o", row, branch_target_o, v.target);
	endtask

	initial begin
		int   i;
		vec_t v;
		vec_t zero_row;
		checks      = 0;
		errors      = 0;
		zero_row    = '0;
		rst_n_i     = 1'b0;
		pc_i        = '0;
		inst_i      = '0;
		reg1_data_i = '0;
		reg2_data_i = '0;
		ex_wreg_i   = 1'b0;
		ex_wd_i     = '0;
		ex_wdata_i  = '0;
		ex_aluop_i  = id_pkg::OP_NOP;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
		void'($urandom(32'h572d6048));

		for (i = 0; i < 8; i++) begin
			wait_clk(1'b1);
		end
		rst_n_i <= 1'b1;
		wait_clk(1'b0);
		check_ex(-1, zero_row); // reset state of the id/ex register

		for (i = 0; i < NUM_VEC; i++) begin
			v = vectors[i];
			wait_clk(1'b1);
			pc_i        <= v.pc;
			inst_i      <= v.inst;
			reg1_data_i <= v.fill ? $urandom : v.r1;
			reg2_data_i <= v.fill ? $urandom : v.r2;
			ex_wreg_i   <= v.ex_wreg;
			ex_wd_i     <= v.ex_wd;
			ex_wdata_i  <= v.ex_wdata;
			ex_aluop_i  <= v.ex_aluop;
			mem_wreg_i  <= v.mem_wreg;
			mem_wd_i    <= v.mem_wd;
			mem_wdata_i <= v.mem_wdata;
			wait_clk(1'b0);
			check("stall_o", i, 32'(stall_o), 32'(v.stall));
			check("reg1_read_o", i, 32'(reg1_read_o), 32'(v.rd1));
			check("reg2_read_o", i, 32'(reg2_read_o), 32'(v.rd2));
			check("reg1_addr_o", i, 32'(reg1_addr_o), 32'(v.ra1));
			check("reg2_addr_o", i, 32'(reg2_addr_o), 32'(v.ra2));
			wait_clk(1'b1); // id/ex capture
			wait_clk(1'b0);
			check_ex(i, v);
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
